//--- Makefile
# Verilator build and run for the L2 interconnect testbench.

VERILATOR ?= verilator
TOP       ?= l2_intc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
rtl/l2_intc_pkg.sv
rtl/l2_req_mux2.sv
rtl/l2_bank.sv
rtl/l2_intc_top.sv
testbench/l2_intc_assert.sv
testbench/l2_intc_tb.sv

//--- rtl/l2_bank.sv
`timescale 1ns/1ps

module l2_bank import l2_intc_pkg::*; #(
	parameter int N_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst_n,

	// request from the root of the tree.
	input  logic              req_i,
	input  l2_tagged_req_t    data_i,
	output logic              gnt_o,

	// response, one valid bit per initiator.
	output logic [N_INIT-1:0] rsp_valid_o,
	output l2_rsp_t           rsp_o
);

	localparam int OFFSET_W = $clog2(BE_WIDTH); // byte offset inside a word.
	localparam int IDX_W = $clog2(N_WORDS);

	logic [DATA_WIDTH-1:0] mem_q [N_WORDS];

	logic [IDX_W-1:0]      req_idx;
	logic                  req_is_read;
	logic                  raw_stall;
	logic                  hs;

	// one-entry write register.
	logic                  wr_pend_q;
	logic [IDX_W-1:0]      wr_idx_q;
	logic [DATA_WIDTH-1:0] wr_data_q;
	logic [BE_WIDTH-1:0]   wr_be_q;

	logic [N_INIT-1:0]     rsp_valid_q;
	logic [DATA_WIDTH-1:0] rdata_q;

	// --------------------------------------------------
	// request decode and grant
	// --------------------------------------------------

	assign req_idx = data_i.req.addr[OFFSET_W +: IDX_W];
	assign req_is_read = data_i.req.wen;

	// The write accepted last cycle is still in the write register and not yet
	// in the array, so a read of that same word has to wait one cycle.
	assign raw_stall = wr_pend_q & req_is_read & (req_idx == wr_idx_q);

	assign gnt_o = req_i & ~raw_stall;
	assign hs = req_i & gnt_o;

	// --------------------------------------------------
	// write register and commit
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_pend_q <= 1'b0;
		end else begin
			wr_pend_q <= hs & ~req_is_read;
		end
	end

	always_ff @(posedge clk) begin
		if (hs && !req_is_read) begin
			wr_idx_q <= req_idx;
			wr_data_q <= data_i.req.wdata;
			wr_be_q <= data_i.req.be;
		end
	end

	// commit lands in the array one cycle after acceptance.
	always_ff @(posedge clk) begin
		if (wr_pend_q) begin
			for (int b = 0; b < BE_WIDTH; b++) begin
				if (wr_be_q[b]) begin
					mem_q[wr_idx_q][b*8 +: 8] <= wr_data_q[b*8 +: 8];
				end
			end
		end
	end

	// --------------------------------------------------
	// read path
	// --------------------------------------------------

	// A granted read never hits the word being committed at this edge, because
	// that case was stalled above.
	always_ff @(posedge clk) begin
		if (hs) begin
			if (req_is_read) begin
				rdata_q <= mem_q[req_idx];
			end else begin
				rdata_q <= '0; // writes return zero data.
			end
		end
	end

	assign rsp_o.rdata = rdata_q;

	// --------------------------------------------------
	// response routing
	// --------------------------------------------------

	// The id is already one-hot, so it is the valid vector as it stands.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid_q <= '0;
		end else if (hs) begin
			rsp_valid_q <= data_i.id;
		end else begin
			rsp_valid_q <= '0;
		end
	end

	assign rsp_valid_o = rsp_valid_q;

endmodule

//--- rtl/l2_intc_pkg.sv
package l2_intc_pkg;

	// --------------------------------------------------
	// width constants
	// --------------------------------------------------

	localparam int N_INIT = 4; // one-hot id, so this is also the id width.
	localparam int ADDR_WIDTH = 32; // byte address.
	localparam int DATA_WIDTH = 64;
	localparam int BE_WIDTH = DATA_WIDTH / 8;

	// --------------------------------------------------
	// payload types
	// --------------------------------------------------

	// request as issued by an initiator.
	// wen high means read, low means write.
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic                  wen;
		logic [DATA_WIDTH-1:0] wdata;
		logic [BE_WIDTH-1:0]   be;
	} l2_req_t;

	// request after tagging at the leaves of the arbitration tree.
	typedef struct packed {
		l2_req_t           req;
		logic [N_INIT-1:0] id; // one bit per initiator.
	} l2_tagged_req_t;

	// response payload, shared by all initiators.
	typedef struct packed {
		logic [DATA_WIDTH-1:0] rdata;
	} l2_rsp_t;

endpackage

//--- rtl/l2_intc_top.sv
`timescale 1ns/1ps

module l2_intc_top import l2_intc_pkg::*; #(
	parameter int N_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst_n,

	// initiator requests.
	input  logic [N_INIT-1:0] req_i,
	input  l2_req_t           req_data_i [N_INIT],
	output logic [N_INIT-1:0] gnt_o,

	// responses.
	output logic [N_INIT-1:0] rsp_valid_o,
	output l2_rsp_t           rsp_o
);

	l2_tagged_req_t leaf_data [N_INIT];

	// node a, initiators 0 and 1.
	logic           a_req;
	l2_tagged_req_t a_data;
	logic           a_gnt;

	// node b, initiators 2 and 3.
	logic           b_req;
	l2_tagged_req_t b_data;
	logic           b_gnt;

	// root to bank.
	logic           bank_req;
	l2_tagged_req_t bank_data;
	logic           bank_gnt;

	// --------------------------------------------------
	// id tagging at the leaves
	// --------------------------------------------------

	for (genvar k = 0; k < N_INIT; k++) begin : g_tag
		assign leaf_data[k] = '{req: req_data_i[k], id: N_INIT'(1) << k};
	end

	// --------------------------------------------------
	// arbitration tree
	// --------------------------------------------------

	l2_req_mux2 u_mux_a (
		.clk        (clk),
		.rst_n      (rst_n),
		.ch0_req_i  (req_i[0]),
		.ch0_data_i (leaf_data[0]),
		.ch0_gnt_o  (gnt_o[0]),
		.ch1_req_i  (req_i[1]),
		.ch1_data_i (leaf_data[1]),
		.ch1_gnt_o  (gnt_o[1]),
		.req_o      (a_req),
		.data_o     (a_data),
		.gnt_i      (a_gnt)
	);

	l2_req_mux2 u_mux_b (
		.clk        (clk),
		.rst_n      (rst_n),
		.ch0_req_i  (req_i[2]),
		.ch0_data_i (leaf_data[2]),
		.ch0_gnt_o  (gnt_o[2]),
		.ch1_req_i  (req_i[3]),
		.ch1_data_i (leaf_data[3]),
		.ch1_gnt_o  (gnt_o[3]),
		.req_o      (b_req),
		.data_o     (b_data),
		.gnt_i      (b_gnt)
	);

	// a bank stall drops the root grant and so holds every node for that cycle.
	l2_req_mux2 u_mux_root (
		.clk        (clk),
		.rst_n      (rst_n),
		.ch0_req_i  (a_req),
		.ch0_data_i (a_data),
		.ch0_gnt_o  (a_gnt),
		.ch1_req_i  (b_req),
		.ch1_data_i (b_data),
		.ch1_gnt_o  (b_gnt),
		.req_o      (bank_req),
		.data_o     (bank_data),
		.gnt_i      (bank_gnt)
	);

	// --------------------------------------------------
	// memory bank
	// --------------------------------------------------

	l2_bank #(
		.N_WORDS (N_WORDS)
	) u_bank (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (bank_req),
		.data_i      (bank_data),
		.gnt_o       (bank_gnt),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

endmodule

//--- rtl/l2_req_mux2.sv
`timescale 1ns/1ps

module l2_req_mux2 import l2_intc_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,

	// channel 0.
	input  logic           ch0_req_i,
	input  l2_tagged_req_t ch0_data_i,
	output logic           ch0_gnt_o,

	// channel 1.
	input  logic           ch1_req_i,
	input  l2_tagged_req_t ch1_data_i,
	output logic           ch1_gnt_o,

	// towards the bank.
	output logic           req_o,
	output l2_tagged_req_t data_o,
	input  logic           gnt_i
);

	logic sel; // low selects channel 0, high selects channel 1.
	logic rr_flag_q;
	logic hs;

	// --------------------------------------------------
	// arbitration
	// --------------------------------------------------

	assign req_o = ch0_req_i | ch1_req_i;

	// channel 1 wins when channel 0 is idle, or when both request and it is its turn.
	assign sel = ~ch0_req_i | (rr_flag_q & ch1_req_i);

	// only the selected channel sees the grant from above.
	assign ch0_gnt_o = ~sel & gnt_i;
	assign ch1_gnt_o = sel & ch1_req_i & gnt_i;

	assign hs = req_o & gnt_i;

	// The flag flips on every transfer through this node, whichever side won.
	// A stalled cycle leaves it unchanged, so the waiting side keeps its turn.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_flag_q <= 1'b0;
		end else if (hs) begin
			rr_flag_q <= ~rr_flag_q;
		end
	end

	// --------------------------------------------------
	// payload selection
	// --------------------------------------------------

	always_comb begin
		if (sel) begin
			data_o = ch1_data_i;
		end else begin
			data_o = ch0_data_i;
		end
	end

endmodule

//--- testbench/l2_intc_assert.sv
`timescale 1ns/1ps

module l2_intc_assert import l2_intc_pkg::*; #(
	parameter int N_WORDS = 256
) (
	input logic              clk,
	input logic              rst_n,
	input logic [N_INIT-1:0] req_i,
	input logic [N_INIT-1:0] gnt_i,
	input logic [N_INIT-1:0] rsp_valid_i,
	input logic              bank_req_i,
	input l2_tagged_req_t    bank_data_i,
	input logic              bank_gnt_i
);

	localparam int IDX_W = $clog2(N_WORDS);

	int unsigned err_cnt = 0; // failed assertion count.

	logic [2:0]       miss_q [N_INIT]; // handshakes lost while requesting.
	logic             wr_q;
	logic [IDX_W-1:0] wr_idx_q;
	logic [IDX_W-1:0] bank_idx;

	assign bank_idx = bank_data_i.req.addr[3 +: IDX_W];

	// --------------------------------------------------
	// helper state
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_q <= 1'b0;
			wr_idx_q <= '0;
			for (int k = 0; k < N_INIT; k++) begin
				miss_q[k] <= '0;
			end
		end else begin
			wr_q <= bank_req_i & bank_gnt_i & ~bank_data_i.req.wen;
			wr_idx_q <= bank_idx;
			for (int k = 0; k < N_INIT; k++) begin
				if (!req_i[k] || gnt_i[k]) begin
					miss_q[k] <= '0;
				end else if (|(req_i & gnt_i)) begin
					miss_q[k] <= miss_q[k] + 3'd1;
				end
			end
		end
	end

	// --------------------------------------------------
	// properties
	// --------------------------------------------------

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt_i) && ((gnt_i & ~req_i) == '0))
		else begin err_cnt++; $error("illegal grant vector %h", gnt_i); end

	a_rsp_timing: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid_i == $past(req_i & gnt_i))
		else begin err_cnt++; $error("response valid %h out of step", rsp_valid_i); end

	a_raw_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_q && bank_req_i && bank_data_i.req.wen && bank_idx == wr_idx_q) |-> !bank_gnt_i)
		else begin err_cnt++; $error("read granted on the word written last cycle"); end

	for (genvar k = 0; k < N_INIT; k++) begin : g_fair
		a_fair: assert property (@(posedge clk) disable iff (!rst_n) miss_q[k] <= 3'd3)
			else begin err_cnt++; $error("initiator %0d starved", k); end
	end

endmodule

bind l2_intc_top l2_intc_assert #(
	.N_WORDS (N_WORDS)
) u_assert (
	.clk         (clk),
	.rst_n       (rst_n),
	.req_i       (req_i),
	.gnt_i       (gnt_o),
	.rsp_valid_i (rsp_valid_o),
	.bank_req_i  (bank_req),
	.bank_data_i (bank_data),
	.bank_gnt_i  (bank_gnt)
);

//--- testbench/l2_intc_tb.sv
`timescale 1ns/1ps

module l2_intc_tb import l2_intc_pkg::*; ();

	localparam int N_WORDS = 256;
	localparam int STIM_DLY = 2;
	localparam int GNT_TIMEOUT = 200; // cycles.
	localparam int N_RANDOM = 40; // operations per initiator.

	logic              clk;
	logic              rst_n;
	logic [N_INIT-1:0] req_i;
	l2_req_t           req_data_i [N_INIT];
	logic [N_INIT-1:0] gnt_o;
	logic [N_INIT-1:0] rsp_valid_o;
	l2_rsp_t           rsp_o;

	logic [DATA_WIDTH-1:0] shadow [N_WORDS]; // reference copy of the bank.
	logic                  pend [N_INIT];
	logic [DATA_WIDTH-1:0] exp_data [N_INIT];

	l2_intc_top #(
		.N_WORDS (N_WORDS)
	) u_l2_intc_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (req_i),
		.req_data_i  (req_data_i),
		.gnt_o       (gnt_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	// --------------------------------------------------
	// initiator access, called just after a rising edge
	// --------------------------------------------------

	task automatic access(input int k, input int idx, input logic rd,
			input logic [DATA_WIDTH-1:0] wd, input logic [BE_WIDTH-1:0] be);
		int waited;
		logic [DATA_WIDTH-1:0] expv;
		waited = 0;
		req_data_i[k] = '{addr: 32'(idx) << 3, wen: rd, wdata: wd, be: be};
		req_i[k] = 1'b1;
		@(negedge clk);
		while (!gnt_o[k]) begin
			waited++;
			if (waited > GNT_TIMEOUT) begin
				abort_run($sformatf("timeout waiting for grant of initiator %0d", k));
			end
			@(negedge clk);
		end
		expv = '0; // writes answer with zero data.
		if (rd) begin
			expv = shadow[idx];
		end else begin
			for (int b = 0; b < BE_WIDTH; b++) begin
				if (be[b]) shadow[idx][b*8 +: 8] = wd[b*8 +: 8];
			end
		end
		@(posedge clk); // the transfer happens at this edge.
		pend[k] = 1'b1;
		exp_data[k] = expv;
		#STIM_DLY;
		req_i[k] = 1'b0;
	endtask

	function automatic logic [DATA_WIDTH-1:0] pattern_word(input int idx);
		return {32'(idx) * 32'h9e3779b9, ~32'(idx) ^ 32'h5a5a_0000};
	endfunction

	task automatic fill_range(input int k);
		int idx;
		for (int i = 0; i < N_WORDS / N_INIT; i++) begin
			idx = k * (N_WORDS / N_INIT) + i;
			access(k, idx, 1'b0, pattern_word(idx), '1);
		end
	endtask

	task automatic random_traffic(input int k);
		int idx;
		for (int i = 0; i < N_RANDOM; i++) begin
			idx = int'($urandom_range(N_WORDS - 1));
			access(k, idx, 1'($urandom_range(1)), {$urandom, $urandom}, 8'($urandom));
		end
	endtask

	task automatic readback_stride(input int k);
		for (int idx = k; idx < N_WORDS; idx += N_INIT) begin
			access(k, idx, 1'b1, '0, '0);
		end
	endtask

	// --------------------------------------------------
	// response check
	// --------------------------------------------------

	always @(negedge clk) begin
		if (rst_n) begin
			if (u_l2_intc_top.u_assert.err_cnt != 0) begin
				abort_run("an assertion in l2_intc_assert failed");
			end
			for (int k = 0; k < N_INIT; k++) begin
				if (rsp_valid_o[k]) begin
					if (!pend[k]) begin
						abort_run($sformatf("response to initiator %0d with nothing pending", k));
					end else if (rsp_o.rdata !== exp_data[k]) begin
						$display("CHECK FAILED rsp_o.rdata initiator %0d: got %h expected %h",
							k, rsp_o.rdata, exp_data[k]);
						abort_run("read data mismatch");
					end
					pend[k] = 1'b0;
				end
			end
		end
	end

	initial begin
		void'($urandom(90));
		clk = 1'b0;
		rst_n = 1'b0;
		req_i = '0;
		for (int k = 0; k < N_INIT; k++) begin
			req_data_i[k] = '0;
			pend[k] = 1'b0;
			exp_data[k] = '0;
		end
		repeat (3) @(posedge clk);
		#STIM_DLY;
		rst_n = 1'b1;
		repeat (4) @(posedge clk); // idle, nothing may be granted.
		#STIM_DLY;

		// all four request back to back, which also exercises fairness.
		fork
			fill_range(0);
			fill_range(1);
			fill_range(2);
			fill_range(3);
		join
		fork
			random_traffic(0);
			random_traffic(1);
			random_traffic(2);
			random_traffic(3);
		join

		// read right behind a write to the same word.
		fork
			access(0, 17, 1'b0, 64'h0123_4567_89ab_cdef, 8'hff);
			begin
				@(posedge clk);
				#STIM_DLY;
				access(1, 17, 1'b1, '0, '0);
			end
		join
		fork
			readback_stride(0);
			readback_stride(1);
			readback_stride(2);
			readback_stride(3);
		join
		repeat (3) @(posedge clk);

		if (u_l2_intc_top.u_assert.err_cnt != 0) begin
			abort_run("an assertion in l2_intc_assert failed");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule
